/* common/decode_pkg.sv */
//==============================
// Shared widths, instruction fields and control encodings of decode
// exc_code_e lists only the causes decode can raise
//==============================
package decode_pkg;

   // Datapath and register file sizes
   localparam int XLEN      = 32;
   localparam int RF_AWIDTH = 5;
   localparam int RF_DEPTH  = 32;

   // Instruction field positions
   localparam int OPCODE_LSB = 2;              // Major opcode sits in bits 6:2
   localparam int RD_LSB     = 7;
   localparam int FUNCT3_LSB = 12;
   localparam int RS1_LSB    = 15;
   localparam int RS2_LSB    = 20;
   localparam int FUNCT7_LSB = 25;

   // Legal funct7 values for the base integer set
   localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
   localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // SUB and SRA/SRAI

   // Major opcodes, bits 6:2 of the instruction
   typedef enum logic [4:0] {
      OPCODE_LOAD_INST   = 5'b00000,
      OPCODE_IMM_INST    = 5'b00100,
      OPCODE_AUIPC_INST  = 5'b00101,
      OPCODE_STORE_INST  = 5'b01000,
      OPCODE_ARITH_INST  = 5'b01100,
      OPCODE_LUI_INST    = 5'b01101,
      OPCODE_BRANCH_INST = 5'b11000,
      OPCODE_JALR_INST   = 5'b11001,
      OPCODE_JAL_INST    = 5'b11011
   } rv_opcode_e;

   // Integer ALU operations
   typedef enum logic [3:0] {
      ALU_I_OPS_NONE,
      ALU_I_OPS_ADD,
      ALU_I_OPS_SUB,
      ALU_I_OPS_SLL,
      ALU_I_OPS_SLT,
      ALU_I_OPS_SLTU,
      ALU_I_OPS_XOR,
      ALU_I_OPS_SRL,
      ALU_I_OPS_SRA,
      ALU_I_OPS_OR,
      ALU_I_OPS_AND,
      ALU_I_OPS_COPY_OPR2                      // Pass operand 2 through, used by LUI
   } alu_i_ops_e;

   // Load operations
   typedef enum logic [2:0] {
      LD_OPS_NONE,
      LD_OPS_LB,
      LD_OPS_LH,
      LD_OPS_LW,
      LD_OPS_LBU,
      LD_OPS_LHU
   } ld_ops_e;

   // Store operations
   typedef enum logic [1:0] {
      ST_OPS_NONE,
      ST_OPS_SB,
      ST_OPS_SH,
      ST_OPS_SW
   } st_ops_e;

   // Branch compare operations
   typedef enum logic [2:0] {
      BR_OPS_NONE,
      BR_OPS_EQ,
      BR_OPS_NE,
      BR_OPS_LT,
      BR_OPS_GE,
      BR_OPS_LTU,
      BR_OPS_GEU
   } br_ops_e;

   // ALU operand selects
   typedef enum logic {
      ALU_OPR1_PC,
      ALU_OPR1_REG
   } alu_opr1_sel_e;

   typedef enum logic {
      ALU_OPR2_IMM,
      ALU_OPR2_REG
   } alu_opr2_sel_e;

   // Second operand of the compare unit
   typedef enum logic {
      ALU_CMP_OPR2_REG,
      ALU_CMP_OPR2_IMM
   } alu_cmp_opr2_sel_e;

   // Source of the rd writeback value
   typedef enum logic [1:0] {
      RD_WRB_NONE,
      RD_WRB_ALU,
      RD_WRB_DMEM,
      RD_WRB_INC_PC                            // Return address pc + 4
   } rd_wrb_sel_e;

   // Immediate formats
   typedef enum logic [2:0] {
      IMM_FMT_I,
      IMM_FMT_SHAMT,
      IMM_FMT_S,
      IMM_FMT_B,
      IMM_FMT_U,
      IMM_FMT_J
   } imm_fmt_e;

   // Exception causes, other codes reserved
   typedef enum logic [3:0] {
      EXC_CODE_NO_EXCEPTION    = 4'd0,
      EXC_CODE_INSTR_ACC_FAULT = 4'd1,
      EXC_CODE_ILLEGAL_INSTR   = 4'd2
   } exc_code_e;

endpackage : decode_pkg

/* hw/reg_file.sv */
//==============================
// Reads are combinational, a same-cycle write is not bypassed
//==============================
module reg_file (
   input  logic                             clk,
   input  logic                             rst_i,
   input  logic [decode_pkg::RF_AWIDTH-1:0] rs1_addr_i,
   input  logic [decode_pkg::RF_AWIDTH-1:0] rs2_addr_i,
   input  logic                             rd_wr_req_i,
   input  logic [decode_pkg::RF_AWIDTH-1:0] rd_addr_i,
   input  logic [decode_pkg::XLEN-1:0]      rd_data_i,
   output logic [decode_pkg::XLEN-1:0]      rs1_data_o,
   output logic [decode_pkg::XLEN-1:0]      rs2_data_o
);

   import decode_pkg::*;

   logic [XLEN-1:0] regs [RF_DEPTH];

   always_ff @(posedge clk) begin
      if (rst_i) begin
         for (int i = 0; i < RF_DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (rd_wr_req_i && (rd_addr_i != '0)) begin
         regs[rd_addr_i] <= rd_data_i;             // x0 stays zero
      end
   end

   // x0 reads as zero
   assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
   assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule : reg_file

/* hw/decode/imm_gen.sv */
//==============================
// Immediate assembly, format comes from the decoder
//==============================
module imm_gen (
   input  logic [decode_pkg::XLEN-1:0] instr_i,
   input  decode_pkg::imm_fmt_e        imm_fmt_i,
   output logic [decode_pkg::XLEN-1:0] imm_o
);

   import decode_pkg::*;

   logic sign;

   assign sign = instr_i[XLEN-1];

   always_comb begin
      case (imm_fmt_i)
         IMM_FMT_I: begin
            imm_o = {{21{sign}}, instr_i[30:20]};
         end
         IMM_FMT_SHAMT: begin
            imm_o = XLEN'(instr_i[RS2_LSB +: RF_AWIDTH]);  // Zero extended
         end
         IMM_FMT_S: begin
            imm_o = {{21{sign}}, instr_i[30:25], instr_i[RD_LSB +: RF_AWIDTH]};
         end
         IMM_FMT_B: begin
            imm_o = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
         end
         IMM_FMT_U: begin
            imm_o = {instr_i[XLEN-1:FUNCT3_LSB], 12'b0};
         end
         IMM_FMT_J: begin
            imm_o = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
         end
         default: begin
            imm_o = '0;                            // Unused encodings
         end
      endcase
   end

endmodule : imm_gen

/* hw/decode/instr_decoder.sv */
//==============================
// RV32I base set only, other opcodes decode as illegal
// A fetch exception wins over the illegal check
//==============================
module instr_decoder (
   input  logic [decode_pkg::XLEN-1:0]   instr_i,
   input  logic                          fetch_exc_req_i,
   input  decode_pkg::exc_code_e         fetch_exc_code_i,
   output decode_pkg::imm_fmt_e          imm_fmt_o,
   output decode_pkg::alu_i_ops_e        alu_i_ops_o,
   output decode_pkg::ld_ops_e           ld_ops_o,
   output decode_pkg::st_ops_e           st_ops_o,
   output decode_pkg::br_ops_e           branch_ops_o,
   output decode_pkg::alu_opr1_sel_e     alu_opr1_sel_o,
   output decode_pkg::alu_opr2_sel_e     alu_opr2_sel_o,
   output decode_pkg::alu_cmp_opr2_sel_e alu_cmp_opr2_sel_o,
   output decode_pkg::rd_wrb_sel_e       rd_wrb_sel_o,
   output logic                          rd_wr_req_o,
   output logic                          jump_req_o,
   output logic                          branch_req_o,
   output logic                          exc_req_o,
   output decode_pkg::exc_code_e         exc_code_o
);

   import decode_pkg::*;

   rv_opcode_e  opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic        illegal_instr;

   assign opcode = rv_opcode_e'(instr_i[OPCODE_LSB +: $bits(rv_opcode_e)]);
   assign funct3 = instr_i[FUNCT3_LSB +: 3];
   assign funct7 = instr_i[FUNCT7_LSB +: 7];

   always_comb begin
      alu_i_ops_o        = ALU_I_OPS_NONE;
      ld_ops_o           = LD_OPS_NONE;
      st_ops_o           = ST_OPS_NONE;
      branch_ops_o       = BR_OPS_NONE;
      alu_opr1_sel_o     = ALU_OPR1_PC;
      alu_opr2_sel_o     = ALU_OPR2_IMM;
      alu_cmp_opr2_sel_o = ALU_CMP_OPR2_REG;
      rd_wrb_sel_o       = RD_WRB_NONE;
      rd_wr_req_o        = 1'b0;
      jump_req_o         = 1'b0;
      branch_req_o       = 1'b0;
      exc_req_o          = 1'b0;
      exc_code_o         = EXC_CODE_NO_EXCEPTION;
      imm_fmt_o          = IMM_FMT_I;
      illegal_instr      = 1'b0;

      case (opcode)
         OPCODE_ARITH_INST: begin
            rd_wrb_sel_o   = RD_WRB_ALU;
            alu_opr1_sel_o = ALU_OPR1_REG;
            alu_opr2_sel_o = ALU_OPR2_REG;
            rd_wr_req_o    = 1'b1;
            if (funct7 == FUNCT7_BASE) begin
               case (funct3)
                  3'b000:  alu_i_ops_o = ALU_I_OPS_ADD;
                  3'b001:  alu_i_ops_o = ALU_I_OPS_SLL;
                  3'b010:  alu_i_ops_o = ALU_I_OPS_SLT;
                  3'b011:  alu_i_ops_o = ALU_I_OPS_SLTU;
                  3'b100:  alu_i_ops_o = ALU_I_OPS_XOR;
                  3'b101:  alu_i_ops_o = ALU_I_OPS_SRL;
                  3'b110:  alu_i_ops_o = ALU_I_OPS_OR;
                  default: alu_i_ops_o = ALU_I_OPS_AND;
               endcase
            end else if (funct7 == FUNCT7_ALT && funct3 == 3'b000) begin
               alu_i_ops_o = ALU_I_OPS_SUB;
            end else if (funct7 == FUNCT7_ALT && funct3 == 3'b101) begin
               alu_i_ops_o = ALU_I_OPS_SRA;
            end else begin
               illegal_instr = 1'b1;                // M and Zba land here too
            end
         end

         OPCODE_IMM_INST: begin
            rd_wrb_sel_o       = RD_WRB_ALU;
            alu_opr1_sel_o     = ALU_OPR1_REG;
            alu_cmp_opr2_sel_o = ALU_CMP_OPR2_IMM;  // SLTI/SLTIU compare against imm
            rd_wr_req_o        = 1'b1;
            case (funct3)
               3'b000: alu_i_ops_o = ALU_I_OPS_ADD;
               3'b010: alu_i_ops_o = ALU_I_OPS_SLT;
               3'b011: alu_i_ops_o = ALU_I_OPS_SLTU;
               3'b100: alu_i_ops_o = ALU_I_OPS_XOR;
               3'b110: alu_i_ops_o = ALU_I_OPS_OR;
               3'b111: alu_i_ops_o = ALU_I_OPS_AND;
               3'b001: begin
                  imm_fmt_o   = IMM_FMT_SHAMT;
                  alu_i_ops_o = ALU_I_OPS_SLL;
                  if (funct7 != FUNCT7_BASE) illegal_instr = 1'b1;
               end
               default: begin                       // 3'b101, SRLI or SRAI
                  imm_fmt_o = IMM_FMT_SHAMT;
                  if (funct7 == FUNCT7_BASE) begin
                     alu_i_ops_o = ALU_I_OPS_SRL;
                  end else if (funct7 == FUNCT7_ALT) begin
                     alu_i_ops_o = ALU_I_OPS_SRA;
                  end else begin
                     illegal_instr = 1'b1;
                  end
               end
            endcase
         end

         OPCODE_AUIPC_INST: begin
            imm_fmt_o    = IMM_FMT_U;
            rd_wrb_sel_o = RD_WRB_ALU;
            alu_i_ops_o  = ALU_I_OPS_ADD;           // pc + upper imm
            rd_wr_req_o  = 1'b1;
         end

         OPCODE_LUI_INST: begin
            imm_fmt_o    = IMM_FMT_U;
            rd_wrb_sel_o = RD_WRB_ALU;
            alu_i_ops_o  = ALU_I_OPS_COPY_OPR2;
            rd_wr_req_o  = 1'b1;
         end

         OPCODE_LOAD_INST: begin
            rd_wrb_sel_o   = RD_WRB_DMEM;
            alu_opr1_sel_o = ALU_OPR1_REG;
            alu_i_ops_o    = ALU_I_OPS_ADD;         // Address generation
            rd_wr_req_o    = 1'b1;
            case (funct3)
               3'b000:  ld_ops_o      = LD_OPS_LB;
               3'b001:  ld_ops_o      = LD_OPS_LH;
               3'b010:  ld_ops_o      = LD_OPS_LW;
               3'b100:  ld_ops_o      = LD_OPS_LBU;
               3'b101:  ld_ops_o      = LD_OPS_LHU;
               default: illegal_instr = 1'b1;
            endcase
         end

         OPCODE_STORE_INST: begin
            imm_fmt_o      = IMM_FMT_S;
            alu_opr1_sel_o = ALU_OPR1_REG;
            alu_i_ops_o    = ALU_I_OPS_ADD;
            case (funct3)
               3'b000:  st_ops_o      = ST_OPS_SB;
               3'b001:  st_ops_o      = ST_OPS_SH;
               3'b010:  st_ops_o      = ST_OPS_SW;
               default: illegal_instr = 1'b1;
            endcase
         end

         OPCODE_BRANCH_INST: begin
            imm_fmt_o    = IMM_FMT_B;
            alu_i_ops_o  = ALU_I_OPS_ADD;           // Target is pc + imm
            branch_req_o = 1'b1;
            case (funct3)
               3'b000:  branch_ops_o  = BR_OPS_EQ;
               3'b001:  branch_ops_o  = BR_OPS_NE;
               3'b100:  branch_ops_o  = BR_OPS_LT;
               3'b101:  branch_ops_o  = BR_OPS_GE;
               3'b110:  branch_ops_o  = BR_OPS_LTU;
               3'b111:  branch_ops_o  = BR_OPS_GEU;
               default: illegal_instr = 1'b1;
            endcase
         end

         OPCODE_JALR_INST: begin
            rd_wrb_sel_o   = RD_WRB_INC_PC;
            alu_opr1_sel_o = ALU_OPR1_REG;
            alu_i_ops_o    = ALU_I_OPS_ADD;
            rd_wr_req_o    = 1'b1;
            jump_req_o     = 1'b1;                  // Target only known after execute
            if (funct3 != 3'b000) illegal_instr = 1'b1;
         end

         OPCODE_JAL_INST: begin
            imm_fmt_o    = IMM_FMT_J;
            rd_wrb_sel_o = RD_WRB_INC_PC;
            alu_i_ops_o  = ALU_I_OPS_ADD;
            rd_wr_req_o  = 1'b1;                    // Fetch already redirected, no jump_req
         end

         default: illegal_instr = 1'b1;
      endcase

      // 32-bit encodings end in 11, anything else is an unknown opcode
      if (instr_i[OPCODE_LSB-1:0] != 2'b11) begin
         illegal_instr = 1'b1;
         imm_fmt_o     = IMM_FMT_I;
      end

      // Squash everything on an exception
      if (illegal_instr || fetch_exc_req_i) begin
         alu_i_ops_o  = ALU_I_OPS_NONE;
         ld_ops_o     = LD_OPS_NONE;
         st_ops_o     = ST_OPS_NONE;
         branch_ops_o = BR_OPS_NONE;
         rd_wrb_sel_o = RD_WRB_NONE;
         rd_wr_req_o  = 1'b0;
         jump_req_o   = 1'b0;
         branch_req_o = 1'b0;
         exc_req_o    = 1'b1;
         exc_code_o   = fetch_exc_req_i ? fetch_exc_code_i : EXC_CODE_ILLEGAL_INSTR;
      end
   end

endmodule : instr_decoder

/* hw/decode/decode_stage.sv */
//==============================
// Decode is combinational with no handshake
// Stalls hold instr_i upstream
//==============================
module decode_stage (
   input  logic                              clk,
   input  logic                              rst_i,

   // From fetch
   input  logic [decode_pkg::XLEN-1:0]       instr_i,
   input  logic                              fetch_exc_req_i,
   input  decode_pkg::exc_code_e             fetch_exc_code_i,

   // From writeback
   input  logic                              wrb_rd_wr_req_i,
   input  logic [decode_pkg::RF_AWIDTH-1:0]  wrb_rd_addr_i,
   input  logic [decode_pkg::XLEN-1:0]       wrb_rd_data_i,

   // To execute
   output decode_pkg::alu_i_ops_e            alu_i_ops_o,
   output decode_pkg::ld_ops_e               ld_ops_o,
   output decode_pkg::st_ops_e               st_ops_o,
   output decode_pkg::br_ops_e               branch_ops_o,
   output decode_pkg::alu_opr1_sel_e         alu_opr1_sel_o,
   output decode_pkg::alu_opr2_sel_e         alu_opr2_sel_o,
   output decode_pkg::alu_cmp_opr2_sel_e     alu_cmp_opr2_sel_o,
   output decode_pkg::rd_wrb_sel_e           rd_wrb_sel_o,
   output logic                              rd_wr_req_o,
   output logic                              jump_req_o,
   output logic                              branch_req_o,
   output logic                              exc_req_o,
   output decode_pkg::exc_code_e             exc_code_o,
   output logic [decode_pkg::XLEN-1:0]       imm_o,
   output logic [decode_pkg::XLEN-1:0]       rs1_data_o,
   output logic [decode_pkg::XLEN-1:0]       rs2_data_o
);

   import decode_pkg::*;

   imm_fmt_e              imm_fmt;
   logic [RF_AWIDTH-1:0]  rs1_addr;
   logic [RF_AWIDTH-1:0]  rs2_addr;

   assign rs1_addr = instr_i[RS1_LSB +: RF_AWIDTH];
   assign rs2_addr = instr_i[RS2_LSB +: RF_AWIDTH];

   instr_decoder u_instr_decoder (
      .instr_i            (instr_i),
      .fetch_exc_req_i    (fetch_exc_req_i),
      .fetch_exc_code_i   (fetch_exc_code_i),
      .imm_fmt_o          (imm_fmt),
      .alu_i_ops_o        (alu_i_ops_o),
      .ld_ops_o           (ld_ops_o),
      .st_ops_o           (st_ops_o),
      .branch_ops_o       (branch_ops_o),
      .alu_opr1_sel_o     (alu_opr1_sel_o),
      .alu_opr2_sel_o     (alu_opr2_sel_o),
      .alu_cmp_opr2_sel_o (alu_cmp_opr2_sel_o),
      .rd_wrb_sel_o       (rd_wrb_sel_o),
      .rd_wr_req_o        (rd_wr_req_o),
      .jump_req_o         (jump_req_o),
      .branch_req_o       (branch_req_o),
      .exc_req_o          (exc_req_o),
      .exc_code_o         (exc_code_o)
   );

   imm_gen u_imm_gen (
      .instr_i   (instr_i),
      .imm_fmt_i (imm_fmt),
      .imm_o     (imm_o)
   );

   reg_file u_reg_file (
      .clk         (clk),
      .rst_i       (rst_i),
      .rs1_addr_i  (rs1_addr),
      .rs2_addr_i  (rs2_addr),
      .rd_wr_req_i (wrb_rd_wr_req_i),
      .rd_addr_i   (wrb_rd_addr_i),
      .rd_data_i   (wrb_rd_data_i),
      .rs1_data_o  (rs1_data_o),
      .rs2_data_o  (rs2_data_o)
   );

endmodule : decode_stage

/* sim/decode_tests.svh */
//==============================
// Directed tests and RV32 encoders
// Shares signals and check tasks with the testbench module
//==============================

// Base format encoders, low two bits always 11
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] op);
   return {f7, rs2, rs1, f3, rd, op, 2'b11};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [4:0] op);
   return {imm, rs1, f3, rd, op, 2'b11};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
   return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE_INST, 2'b11};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
   return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH_INST, 2'b11};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [4:0] op);
   return {imm, rd, op, 2'b11};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL_INST, 2'b11};
endfunction

task automatic test_reg_file();
   logic [4:0]  addrs [6];
   logic [31:0] data;
   int          nxt;
   addrs = '{5'd1, 5'd0, 5'd9, 5'd31, 5'd9, 5'd17};    // x9 written twice
   for (int i = 0; i < 6; i++) begin
      data = $random(seed);
      drive_cycle(enc_r(FUNCT7_BASE, addrs[i], addrs[i], 3'b000, 5'd3, OPCODE_ARITH_INST),
                  1'b0, EXC_CODE_NO_EXCEPTION, 1'b1, addrs[i], data);
      check_value("rf_same_cycle_rs1", rf_model[addrs[i]], rs1_data_o); // Old value
      check_value("rf_same_cycle_rs2", rf_model[addrs[i]], rs2_data_o);
      if (addrs[i] != 5'd0) begin
         rf_model[addrs[i]] = data;
      end
   end
   for (int i = 0; i < 6; i++) begin
      nxt = (i + 1) % 6;
      drive_instr(enc_r(FUNCT7_BASE, addrs[nxt], addrs[i], 3'b000, 5'd3, OPCODE_ARITH_INST));
      check_value("rf_read_rs1", rf_model[addrs[i]], rs1_data_o);
      check_value("rf_read_rs2", rf_model[addrs[nxt]], rs2_data_o);
   end
endtask

task automatic test_alu_decode();
   alu_i_ops_e  exp_ops [8];
   logic [11:0] imm;
   logic [4:0]  shamt;
   exp_ops = '{ALU_I_OPS_ADD, ALU_I_OPS_SLL, ALU_I_OPS_SLT, ALU_I_OPS_SLTU,
               ALU_I_OPS_XOR, ALU_I_OPS_SRL, ALU_I_OPS_OR, ALU_I_OPS_AND};
   for (int f3 = 0; f3 < 8; f3++) begin
      drive_instr(enc_r(FUNCT7_BASE, 5'd2, 5'd1, 3'(f3), 5'd3, OPCODE_ARITH_INST));
      check_ok("r_alu", exp_ops[f3], LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE, RD_WRB_ALU,
               1'b1, 1'b0, 1'b0);
      check_sel("r_alu", ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG);
      shamt = 5'($random(seed));
      imm   = 12'($random(seed));
      if (f3 == 1 || f3 == 5) begin
         imm = {FUNCT7_BASE, shamt};
      end
      drive_instr(enc_i(imm, 5'd1, 3'(f3), 5'd3, OPCODE_IMM_INST));
      check_ok("i_alu", exp_ops[f3], LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE, RD_WRB_ALU,
               1'b1, 1'b0, 1'b0);
      check_sel("i_alu", ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_IMM);
      if (f3 == 1 || f3 == 5) begin
         check_value("i_shamt", {27'b0, shamt}, imm_o);
      end else begin
         check_value("i_imm", {{20{imm[11]}}, imm}, imm_o);
      end
   end
   drive_instr(enc_r(FUNCT7_ALT, 5'd2, 5'd1, 3'b000, 5'd3, OPCODE_ARITH_INST));
   check_ok("sub", ALU_I_OPS_SUB, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE, RD_WRB_ALU,
            1'b1, 1'b0, 1'b0);
   drive_instr(enc_r(FUNCT7_ALT, 5'd2, 5'd1, 3'b101, 5'd3, OPCODE_ARITH_INST));
   check_ok("sra", ALU_I_OPS_SRA, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE, RD_WRB_ALU,
            1'b1, 1'b0, 1'b0);
   shamt = 5'($random(seed));
   drive_instr(enc_i({FUNCT7_ALT, shamt}, 5'd1, 3'b101, 5'd3, OPCODE_IMM_INST));
   check_ok("srai", ALU_I_OPS_SRA, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE, RD_WRB_ALU,
            1'b1, 1'b0, 1'b0);
   check_value("srai_shamt", {27'b0, shamt}, imm_o);    // Bit 10 of the field must not leak
   drive_instr(enc_r(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, OPCODE_ARITH_INST));
   check_squashed("r_funct7_mul", EXC_CODE_ILLEGAL_INSTR);
endtask

task automatic test_imm_formats();
   logic [11:0] imm12;
   logic [12:0] imm13;
   logic [19:0] imm20;
   logic [20:0] imm21;
   for (int n = 0; n < 4; n++) begin
      imm12 = 12'($random(seed));
      drive_instr(enc_i(imm12, 5'd4, 3'b010, 5'd6, OPCODE_LOAD_INST));
      check_value("imm_i_load", {{20{imm12[11]}}, imm12}, imm_o);
      imm12 = 12'($random(seed));
      drive_instr(enc_s(imm12, 5'd5, 5'd4, 3'b010));
      check_value("imm_s_store", {{20{imm12[11]}}, imm12}, imm_o);
      imm13    = 13'($random(seed));
      imm13[0] = 1'b0;                                   // Branch offsets are even
      drive_instr(enc_b(imm13, 5'd5, 5'd4, 3'b000));
      check_value("imm_b_branch", {{19{imm13[12]}}, imm13}, imm_o);
      imm20 = 20'($random(seed));
      drive_instr(enc_u(imm20, 5'd7, OPCODE_LUI_INST));
      check_value("imm_u_lui", {imm20, 12'b0}, imm_o);
      check_ok("lui", ALU_I_OPS_COPY_OPR2, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE, RD_WRB_ALU,
               1'b1, 1'b0, 1'b0);
      drive_instr(enc_u(imm20, 5'd7, OPCODE_AUIPC_INST));
      check_value("imm_u_auipc", {imm20, 12'b0}, imm_o);
      check_ok("auipc", ALU_I_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE, RD_WRB_ALU,
               1'b1, 1'b0, 1'b0);
      imm21    = 21'($random(seed));
      imm21[0] = 1'b0;
      drive_instr(enc_j(imm21, 5'd1));
      check_value("imm_j_jal", {{11{imm21[20]}}, imm21}, imm_o);
   end
endtask

task automatic test_mem_ctrl();
   ld_ops_e ld_exp [8];
   br_ops_e br_exp [8];
   st_ops_e st_exp [4];
   ld_exp = '{LD_OPS_LB, LD_OPS_LH, LD_OPS_LW, LD_OPS_NONE,
              LD_OPS_LBU, LD_OPS_LHU, LD_OPS_NONE, LD_OPS_NONE};
   br_exp = '{BR_OPS_EQ, BR_OPS_NE, BR_OPS_NONE, BR_OPS_NONE,
              BR_OPS_LT, BR_OPS_GE, BR_OPS_LTU, BR_OPS_GEU};
   st_exp = '{ST_OPS_SB, ST_OPS_SH, ST_OPS_SW, ST_OPS_NONE};
   for (int f3 = 0; f3 < 8; f3++) begin
      drive_instr(enc_i(12'h010, 5'd4, 3'(f3), 5'd6, OPCODE_LOAD_INST));
      if (ld_exp[f3] == LD_OPS_NONE) begin
         check_squashed("load_bad_funct3", EXC_CODE_ILLEGAL_INSTR);
      end else begin
         check_ok("load", ALU_I_OPS_ADD, ld_exp[f3], ST_OPS_NONE, BR_OPS_NONE, RD_WRB_DMEM,
                  1'b1, 1'b0, 1'b0);
      end
      drive_instr(enc_b(13'h0020, 5'd5, 5'd4, 3'(f3)));
      if (br_exp[f3] == BR_OPS_NONE) begin
         check_squashed("branch_bad_funct3", EXC_CODE_ILLEGAL_INSTR);
      end else begin
         check_ok("branch", ALU_I_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, br_exp[f3], RD_WRB_NONE,
                  1'b0, 1'b0, 1'b1);
      end
   end
   for (int f3 = 0; f3 < 4; f3++) begin
      drive_instr(enc_s(12'h008, 5'd5, 5'd4, 3'(f3)));
      if (st_exp[f3] == ST_OPS_NONE) begin
         check_squashed("store_bad_funct3", EXC_CODE_ILLEGAL_INSTR);
      end else begin
         check_ok("store", ALU_I_OPS_ADD, LD_OPS_NONE, st_exp[f3], BR_OPS_NONE, RD_WRB_NONE,
                  1'b0, 1'b0, 1'b0);
      end
   end
   drive_instr(enc_i(12'h004, 5'd1, 3'b000, 5'd1, OPCODE_JALR_INST));
   check_ok("jalr", ALU_I_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE, RD_WRB_INC_PC,
            1'b1, 1'b1, 1'b0);
   drive_instr(enc_j(21'h000100, 5'd1));
   check_ok("jal", ALU_I_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE, RD_WRB_INC_PC,
            1'b1, 1'b0, 1'b0);                           // Fetch redirects JAL itself
endtask

task automatic test_exceptions();
   logic [4:0] bad_ops [3];
   bad_ops = '{5'b11100, 5'b01011, 5'b00011};            // System, atomics, fence
   foreach (bad_ops[i]) begin
      drive_instr(enc_i(12'h000, 5'd0, 3'b000, 5'd0, bad_ops[i]));
      check_squashed("unknown_opcode", EXC_CODE_ILLEGAL_INSTR);
   end
   drive_instr(enc_i(12'h000, 5'd4, 3'b011, 5'd6, OPCODE_LOAD_INST));
   check_squashed("load_funct3_3", EXC_CODE_ILLEGAL_INSTR);
   drive_instr(enc_b(13'h0010, 5'd5, 5'd4, 3'b010));
   check_squashed("branch_funct3_2", EXC_CODE_ILLEGAL_INSTR);
   drive_cycle(enc_r(FUNCT7_BASE, 5'd2, 5'd1, 3'b000, 5'd3, OPCODE_ARITH_INST),
               1'b1, EXC_CODE_INSTR_ACC_FAULT, 1'b0, '0, '0);
   check_squashed("fetch_exc_add", EXC_CODE_INSTR_ACC_FAULT);
   drive_cycle(enc_i(12'h000, 5'd0, 3'b000, 5'd0, 5'b11100),
               1'b1, EXC_CODE_INSTR_ACC_FAULT, 1'b0, '0, '0);
   check_squashed("fetch_exc_illegal", EXC_CODE_INSTR_ACC_FAULT); // Fetch code wins
endtask

/* sim/tb_decode_stage.sv */
//==============================
// Directed testbench, stops at the first error
// Inputs change on the falling edge, outputs sampled 2 ns later
//==============================
module tb_decode_stage;
   timeunit 1ns;
   timeprecision 1ps;

   import decode_pkg::*;

   localparam int EDGE_LIMIT = 8;            // Clock transitions before a wait gives up

   logic                  clk;
   logic                  rst_i;
   logic [XLEN-1:0]       instr_i;
   logic                  fetch_exc_req_i;
   exc_code_e             fetch_exc_code_i;
   logic                  wrb_rd_wr_req_i;
   logic [RF_AWIDTH-1:0]  wrb_rd_addr_i;
   logic [XLEN-1:0]       wrb_rd_data_i;
   alu_i_ops_e            alu_i_ops_o;
   ld_ops_e               ld_ops_o;
   st_ops_e               st_ops_o;
   br_ops_e               branch_ops_o;
   alu_opr1_sel_e         alu_opr1_sel_o;
   alu_opr2_sel_e         alu_opr2_sel_o;
   alu_cmp_opr2_sel_e     alu_cmp_opr2_sel_o;
   rd_wrb_sel_e           rd_wrb_sel_o;
   logic                  rd_wr_req_o;
   logic                  jump_req_o;
   logic                  branch_req_o;
   logic                  exc_req_o;
   exc_code_e             exc_code_o;
   logic [XLEN-1:0]       imm_o;
   logic [XLEN-1:0]       rs1_data_o;
   logic [XLEN-1:0]       rs2_data_o;

   int                    seed = 51;
   logic [XLEN-1:0]       rf_model [RF_DEPTH]; // Expected register contents

   decode_stage u_dut (
      .clk                (clk),
      .rst_i              (rst_i),
      .instr_i            (instr_i),
      .fetch_exc_req_i    (fetch_exc_req_i),
      .fetch_exc_code_i   (fetch_exc_code_i),
      .wrb_rd_wr_req_i    (wrb_rd_wr_req_i),
      .wrb_rd_addr_i      (wrb_rd_addr_i),
      .wrb_rd_data_i      (wrb_rd_data_i),
      .alu_i_ops_o        (alu_i_ops_o),
      .ld_ops_o           (ld_ops_o),
      .st_ops_o           (st_ops_o),
      .branch_ops_o       (branch_ops_o),
      .alu_opr1_sel_o     (alu_opr1_sel_o),
      .alu_opr2_sel_o     (alu_opr2_sel_o),
      .alu_cmp_opr2_sel_o (alu_cmp_opr2_sel_o),
      .rd_wrb_sel_o       (rd_wrb_sel_o),
      .rd_wr_req_o        (rd_wr_req_o),
      .jump_req_o         (jump_req_o),
      .branch_req_o       (branch_req_o),
      .exc_req_o          (exc_req_o),
      .exc_code_o         (exc_code_o),
      .imm_o              (imm_o),
      .rs1_data_o         (rs1_data_o),
      .rs2_data_o         (rs2_data_o)
   );

   always #4 clk = ~clk;                     // 8 ns period

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic wait_fall();
      int edges;
      edges = 0;
      @(clk);
      while (clk !== 1'b0 && edges < EDGE_LIMIT) begin
         @(clk);
         edges++;
      end
      if (clk !== 1'b0) begin
         report_failure("Timeout: the clock never went low");
      end
   endtask

   task automatic drive_cycle(input logic [XLEN-1:0] instr, input logic exc_req,
                              input exc_code_e exc_code, input logic wr,
                              input logic [RF_AWIDTH-1:0] wr_addr, input logic [XLEN-1:0] wr_data);
      wait_fall();
      instr_i          = instr;
      fetch_exc_req_i  = exc_req;
      fetch_exc_code_i = exc_code;
      wrb_rd_wr_req_i  = wr;
      wrb_rd_addr_i    = wr_addr;
      wrb_rd_data_i    = wr_data;
      #2;                                    // Let the decode paths settle
   endtask

   task automatic drive_instr(input logic [XLEN-1:0] instr);
      drive_cycle(instr, 1'b0, EXC_CODE_NO_EXCEPTION, 1'b0, '0, '0);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         report_failure($sformatf("MISMATCH test=%s expected=0x%08h actual=0x%08h",
                                  name, expected, actual));
      end
   endtask

   task automatic check_ctrl(input string name, input alu_i_ops_e alu, input ld_ops_e ld,
                             input st_ops_e st, input br_ops_e br, input rd_wrb_sel_e wrb,
                             input logic wr, input logic jmp, input logic brq,
                             input logic exc, input exc_code_e code);
      check_value({name, ".alu_i_ops"}, alu, alu_i_ops_o);
      check_value({name, ".ld_ops"}, ld, ld_ops_o);
      check_value({name, ".st_ops"}, st, st_ops_o);
      check_value({name, ".branch_ops"}, br, branch_ops_o);
      check_value({name, ".rd_wrb_sel"}, wrb, rd_wrb_sel_o);
      check_value({name, ".rd_wr_req"}, wr, rd_wr_req_o);
      check_value({name, ".jump_req"}, jmp, jump_req_o);
      check_value({name, ".branch_req"}, brq, branch_req_o);
      check_value({name, ".exc_req"}, exc, exc_req_o);
      check_value({name, ".exc_code"}, code, exc_code_o);
   endtask

   // Legal decode, no exception expected
   task automatic check_ok(input string name, input alu_i_ops_e alu, input ld_ops_e ld,
                           input st_ops_e st, input br_ops_e br, input rd_wrb_sel_e wrb,
                           input logic wr, input logic jmp, input logic brq);
      check_ctrl(name, alu, ld, st, br, wrb, wr, jmp, brq, 1'b0, EXC_CODE_NO_EXCEPTION);
   endtask

   task automatic check_squashed(input string name, input exc_code_e code);
      check_ctrl(name, ALU_I_OPS_NONE, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE, RD_WRB_NONE,
                 1'b0, 1'b0, 1'b0, 1'b1, code);
   endtask

   task automatic check_sel(input string name, input alu_opr1_sel_e opr1,
                            input alu_opr2_sel_e opr2, input alu_cmp_opr2_sel_e cmp);
      check_value({name, ".alu_opr1_sel"}, opr1, alu_opr1_sel_o);
      check_value({name, ".alu_opr2_sel"}, opr2, alu_opr2_sel_o);
      check_value({name, ".alu_cmp_opr2_sel"}, cmp, alu_cmp_opr2_sel_o);
   endtask

   `include "decode_tests.svh"

   initial begin
      clk              = 1'b0;
      rst_i            = 1'b1;
      instr_i          = '0;
      fetch_exc_req_i  = 1'b0;
      fetch_exc_code_i = EXC_CODE_NO_EXCEPTION;
      wrb_rd_wr_req_i  = 1'b0;
      wrb_rd_addr_i    = '0;
      wrb_rd_data_i    = '0;
      foreach (rf_model[i]) begin
         rf_model[i] = '0;                   // Reset clears every register
      end
      wait_fall();
      wait_fall();
      rst_i = 1'b0;
      #2;
      check_squashed("reset_instr_zero", EXC_CODE_ILLEGAL_INSTR); // All-zero word is illegal
      test_reg_file();
      test_alu_decode();
      test_imm_formats();
      test_mem_ctrl();
      test_exceptions();
      $display("TB PASSED");
      $finish;
   end

endmodule : tb_decode_stage

/* decode_stage.f */
+incdir+sim
common/decode_pkg.sv
hw/reg_file.sv
hw/decode/imm_gen.sv
hw/decode/instr_decoder.sv
hw/decode/decode_stage.sv
sim/tb_decode_stage.sv
